//--- src/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] word_t;     // one instruction or data word
  typedef logic [4:0]  reg_addr_t; // index of x0..x31
  typedef logic [6:0]  opcode_t;   // bits 6:0 of an instruction
  typedef logic [2:0]  funct3_t;   // bits 14:12 of an instruction

  // major opcodes of the subset this hart runs
  localparam opcode_t OP_REG    = 7'b0110011; // add sub and or xor slt sll srl
  localparam opcode_t OP_IMM    = 7'b0010011; // addi andi ori xori slti
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_LOAD   = 7'b0000011; // every load is a word load
  localparam opcode_t OP_STORE  = 7'b0100011; // every store is a word store
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_SYSTEM = 7'b1110011; // only ebreak matters here

  localparam funct3_t F3_ADD = 3'b000; // sub when funct7 bit 5 is set
  localparam funct3_t F3_SLL = 3'b001;
  localparam funct3_t F3_SLT = 3'b010;
  localparam funct3_t F3_XOR = 3'b100;
  localparam funct3_t F3_SRL = 3'b101;
  localparam funct3_t F3_OR  = 3'b110;
  localparam funct3_t F3_AND = 3'b111;
  localparam funct3_t F3_BEQ = 3'b000; // branch funct3 values share the field
  localparam funct3_t F3_BNE = 3'b001;

  localparam word_t EBREAK_WORD = 32'h0010_0073; // ends the program when it retires

  // operations of the execute stage ALU
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,   // signed compare, result is 0 or 1
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B // lui passes its immediate straight through
  } alu_op_e;

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;

  typedef logic [31:0] pc_t; // byte address of an instruction

  localparam pc_t RESET_ADDR = 32'h0000_0000; // first fetch after reset
  localparam pc_t PC_STEP    = 32'd4;         // instructions are one word apart

  // where the writeback value comes from
  typedef enum logic [1:0] {
    WB_ALU,  // result of the execute stage
    WB_MEM,  // read data of the dmem port
    WB_NONE  // no register write at all
  } wb_sel_e;

endpackage

//--- src/rf_read_if.sv
`timescale 1ns/1ps

// both read ports of the register file, addressed from decode
interface rf_read_if;
  isa_pkg::reg_addr_t rs1_addr;
  isa_pkg::reg_addr_t rs2_addr;
  isa_pkg::word_t     rs1_data; // combinational, includes the writeback bypass
  isa_pkg::word_t     rs2_data;

  modport decoder (
    output rs1_addr, rs2_addr,
    input  rs1_data, rs2_data
  );

  modport regs (
    input  rs1_addr, rs2_addr,
    output rs1_data, rs2_data
  );
endinterface

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic           i_clk,
  input  logic           i_rst,
  input  isa_pkg::word_t i_imem_rdata,
  input  logic           i_stall,
  input  logic           i_redirect,
  input  pipe_pkg::pc_t  i_redirect_pc,
  output pipe_pkg::pc_t  o_imem_raddr,
  output logic           o_id_valid,
  output isa_pkg::word_t o_id_inst,
  output pipe_pkg::pc_t  o_id_pc
);
  import pipe_pkg::*;

  pc_t  pc_q;       // next address to request
  pc_t  id_pc_q;    // address of the word that arrives this cycle
  logic id_valid_q; // low after reset and for a wrong-path word

  // a stalled decode asks for its own word again, so the same word is back next cycle
  assign o_imem_raddr = i_stall ? id_pc_q : pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q       <= RESET_ADDR;
      id_pc_q    <= RESET_ADDR;
      id_valid_q <= 1'b0;
    end else if (i_redirect) begin // a taken branch outranks a stall
      pc_q       <= i_redirect_pc;  // target goes out on the next cycle
      id_valid_q <= 1'b0;           // word in flight came from the fall-through path
    end else if (!i_stall) begin
      pc_q       <= pc_q + PC_STEP;
      id_pc_q    <= pc_q;
      id_valid_q <= 1'b1;
    end
  end

  // the imem read register acts as the instruction half of the fetch/decode register
  assign o_id_inst  = i_imem_rdata;
  assign o_id_pc    = id_pc_q;
  assign o_id_valid = id_valid_q;

endmodule

//--- src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  isa_pkg::word_t     i_inst,
  input  pipe_pkg::pc_t      i_pc,
  rf_read_if.decoder         rf,
  input  isa_pkg::reg_addr_t i_ex_rd,
  input  logic               i_ex_wen,
  input  isa_pkg::reg_addr_t i_mem_rd,
  input  logic               i_mem_wen,
  input  logic               i_redirect,
  output logic               o_stall,
  output logic               o_ex_valid,
  output isa_pkg::word_t     o_ex_inst,
  output pipe_pkg::pc_t      o_ex_pc,
  output isa_pkg::word_t     o_ex_op_a,
  output isa_pkg::word_t     o_ex_op_b,
  output isa_pkg::word_t     o_ex_store_data,
  output isa_pkg::word_t     o_ex_imm,
  output isa_pkg::alu_op_e   o_ex_alu_op,
  output pipe_pkg::wb_sel_e  o_ex_wb_sel,
  output isa_pkg::reg_addr_t o_ex_rd,
  output logic               o_ex_mem_ren,
  output logic               o_ex_mem_wen,
  output logic               o_ex_branch,
  output logic               o_ex_branch_ne
);
  import isa_pkg::*;
  import pipe_pkg::*;

  opcode_t   opcode;
  funct3_t   funct3;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     imm_i, imm_s, imm_b, imm_u;
  alu_op_e   alu_op;
  wb_sel_e   wb_sel;
  word_t     imm;      // the immediate this format uses
  logic      use_imm;  // operand b is the immediate, not rs2
  logic      use_rs1;
  logic      use_rs2;
  logic      mem_ren;
  logic      mem_wen;
  logic      branch;
  logic      hazard_rs1;
  logic      hazard_rs2;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};

  assign rf.rs1_addr = rs1;
  assign rf.rs2_addr = rs2;

  // anything not matched below stays a bubble that still retires
  always_comb begin
    alu_op  = ALU_ADD; // loads, stores and branches all add
    wb_sel  = WB_NONE;
    imm     = imm_i;
    use_imm = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    mem_ren = 1'b0;
    mem_wen = 1'b0;
    branch  = 1'b0;
    case (opcode)
      OP_REG: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        wb_sel  = WB_ALU;
        case (funct3)
          F3_ADD:  alu_op = i_inst[30] ? ALU_SUB : ALU_ADD;
          F3_SLL:  alu_op = ALU_SLL;
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_SRL:  alu_op = ALU_SRL;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: wb_sel = WB_NONE; // sltu is outside the subset
        endcase
      end
      OP_IMM: begin
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        wb_sel  = WB_ALU;
        case (funct3)
          F3_ADD:  alu_op = ALU_ADD; // no subtract form with an immediate
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: wb_sel = WB_NONE; // immediate shifts and sltiu are left out
        endcase
      end
      OP_LUI: begin
        use_imm = 1'b1;
        imm     = imm_u;
        alu_op  = ALU_PASS_B;
        wb_sel  = WB_ALU;
      end
      OP_LOAD: begin
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        wb_sel  = WB_MEM;
        mem_ren = 1'b1;
      end
      OP_STORE: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1; // store data
        use_imm = 1'b1;
        imm     = imm_s;
        mem_wen = 1'b1;
      end
      OP_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm     = imm_b;
        branch  = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
      end
      OP_SYSTEM: wb_sel = WB_NONE; // ebreak only shows up as the halt flag on retire
      default: ;
    endcase
  end

  // without forwarding, a source still being produced in execute or memory must wait
  assign hazard_rs1 = use_rs1 && (rs1 != '0) &&
                      ((i_ex_wen && rs1 == i_ex_rd) || (i_mem_wen && rs1 == i_mem_rd));
  assign hazard_rs2 = use_rs2 && (rs2 != '0) &&
                      ((i_ex_wen && rs2 == i_ex_rd) || (i_mem_wen && rs2 == i_mem_rd));
  assign o_stall    = i_valid && (hazard_rs1 || hazard_rs2);

  always_ff @(posedge i_clk) begin
    if (i_rst || o_stall || i_redirect) begin // bubble into execute
      o_ex_valid   <= 1'b0;
      o_ex_wb_sel  <= WB_NONE;
      o_ex_mem_ren <= 1'b0;
      o_ex_mem_wen <= 1'b0;
      o_ex_branch  <= 1'b0;
    end else begin
      o_ex_valid   <= i_valid;
      o_ex_wb_sel  <= wb_sel;
      o_ex_mem_ren <= mem_ren;
      o_ex_mem_wen <= mem_wen;
      o_ex_branch  <= branch;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_inst       <= i_inst;
    o_ex_pc         <= i_pc;
    o_ex_op_a       <= rf.rs1_data;
    o_ex_op_b       <= use_imm ? imm : rf.rs2_data;
    o_ex_store_data <= rf.rs2_data;
    o_ex_imm        <= imm; // branch offset for the target adder
    o_ex_alu_op     <= alu_op;
    o_ex_rd         <= i_inst[11:7];
    o_ex_branch_ne  <= (funct3 == F3_BNE);
  end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic               i_clk,
  input  logic               i_rst,
  rf_read_if.regs            rf,
  input  logic               i_wen,
  input  isa_pkg::reg_addr_t i_waddr,
  input  isa_pkg::word_t     i_wdata
);
  import isa_pkg::*;

  word_t regs [1:31]; // x0 has no storage

  // x0 reads zero, and a write in this cycle is seen by a read of the same register
  assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 :
                       (i_wen && rf.rs1_addr == i_waddr) ? i_wdata : regs[rf.rs1_addr];
  assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 :
                       (i_wen && rf.rs2_addr == i_waddr) ? i_wdata : regs[rf.rs2_addr];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin // writes to x0 are dropped
      regs[i_waddr] <= i_wdata;
    end
  end

endmodule

//--- src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  isa_pkg::word_t     i_inst,
  input  pipe_pkg::pc_t      i_pc,
  input  isa_pkg::word_t     i_op_a,
  input  isa_pkg::word_t     i_op_b,
  input  isa_pkg::word_t     i_store_data,
  input  isa_pkg::word_t     i_imm,
  input  isa_pkg::alu_op_e   i_alu_op,
  input  pipe_pkg::wb_sel_e  i_wb_sel,
  input  isa_pkg::reg_addr_t i_rd,
  input  logic               i_mem_ren,
  input  logic               i_mem_wen,
  input  logic               i_branch,
  input  logic               i_branch_ne,
  output logic               o_redirect,
  output pipe_pkg::pc_t      o_redirect_pc,
  output isa_pkg::reg_addr_t o_ex_rd,
  output logic               o_ex_wen,
  output logic               o_mem_valid,
  output isa_pkg::word_t     o_mem_inst,
  output pipe_pkg::pc_t      o_mem_pc,
  output pipe_pkg::pc_t      o_mem_next_pc,
  output isa_pkg::word_t     o_mem_result,
  output isa_pkg::word_t     o_mem_store_data,
  output isa_pkg::reg_addr_t o_mem_rd,
  output pipe_pkg::wb_sel_e  o_mem_wb_sel,
  output logic               o_mem_ren,
  output logic               o_mem_wen
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t result; // also the dmem address of lw and sw
  pc_t   target; // branch target
  logic  taken;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    result = i_op_a + i_op_b;
      ALU_SUB:    result = i_op_a - i_op_b;
      ALU_AND:    result = i_op_a & i_op_b;
      ALU_OR:     result = i_op_a | i_op_b;
      ALU_XOR:    result = i_op_a ^ i_op_b;
      ALU_SLT:    result = {31'b0, $signed(i_op_a) < $signed(i_op_b)};
      ALU_SLL:    result = i_op_a << i_op_b[4:0]; // shift amount is the low five bits
      ALU_SRL:    result = i_op_a >> i_op_b[4:0];
      default:    result = i_op_b; // ALU_PASS_B
    endcase
  end

  assign target = i_pc + i_imm;
  // beq is taken on equal operands, bne on unequal ones
  assign taken  = i_valid && i_branch && ((i_op_a == i_op_b) != i_branch_ne);

  assign o_redirect    = taken; // same cycle, fetch and decode squash behind it
  assign o_redirect_pc = target;
  assign o_ex_rd       = i_rd;
  assign o_ex_wen      = i_valid && (i_wb_sel != WB_NONE);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mem_valid  <= 1'b0;
      o_mem_wb_sel <= WB_NONE;
      o_mem_ren    <= 1'b0;
      o_mem_wen    <= 1'b0;
    end else begin
      o_mem_valid  <= i_valid;
      o_mem_wb_sel <= i_wb_sel;
      o_mem_ren    <= i_mem_ren;
      o_mem_wen    <= i_mem_wen;
    end
  end

  always_ff @(posedge i_clk) begin
    o_mem_inst       <= i_inst;
    o_mem_pc         <= i_pc;
    o_mem_next_pc    <= taken ? target : i_pc + PC_STEP; // reported on retire
    o_mem_result     <= result;
    o_mem_store_data <= i_store_data;
    o_mem_rd         <= i_rd;
  end

endmodule

//--- src/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  isa_pkg::word_t     i_inst,
  input  pipe_pkg::pc_t      i_pc,
  input  pipe_pkg::pc_t      i_next_pc,
  input  isa_pkg::word_t     i_result,
  input  isa_pkg::word_t     i_store_data,
  input  isa_pkg::reg_addr_t i_rd,
  input  pipe_pkg::wb_sel_e  i_wb_sel,
  input  logic               i_ren,
  input  logic               i_wen,
  output isa_pkg::reg_addr_t o_mem_rd,
  output logic               o_mem_wen,
  output isa_pkg::word_t     o_dmem_addr,
  output logic               o_dmem_ren,
  output logic               o_dmem_wen,
  output isa_pkg::word_t     o_dmem_wdata,
  input  isa_pkg::word_t     i_dmem_rdata,
  output logic               o_rf_wen,
  output isa_pkg::reg_addr_t o_rf_waddr,
  output isa_pkg::word_t     o_rf_wdata,
  output logic               o_retire_valid,
  output isa_pkg::word_t     o_retire_inst,
  output logic               o_retire_halt,
  output pipe_pkg::pc_t      o_retire_pc,
  output pipe_pkg::pc_t      o_retire_next_pc,
  output isa_pkg::reg_addr_t o_retire_rd_waddr,
  output isa_pkg::word_t     o_retire_rd_wdata,
  output logic               o_retire_dmem_wen,
  output isa_pkg::word_t     o_retire_dmem_addr,
  output isa_pkg::word_t     o_retire_dmem_wdata
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic      wb_valid;
  wb_sel_e   wb_sel;
  logic      wb_dmem_wen;   // this instruction stored a word
  word_t     wb_inst;
  pc_t       wb_pc;
  pc_t       wb_next_pc;
  word_t     wb_result;     // ALU result, or the address of a load or store
  word_t     wb_store_data;
  reg_addr_t wb_rd;
  word_t     wb_data;       // value headed for the register file
  logic      wb_write;

  // memory stage, a bubble never touches dmem
  assign o_dmem_addr  = i_result;
  assign o_dmem_ren   = i_valid && i_ren;
  assign o_dmem_wen   = i_valid && i_wen;
  assign o_dmem_wdata = i_store_data;

  assign o_mem_rd  = i_rd;
  assign o_mem_wen = i_valid && (i_wb_sel != WB_NONE);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb_valid    <= 1'b0;
      wb_sel      <= WB_NONE;
      wb_dmem_wen <= 1'b0;
    end else begin
      wb_valid    <= i_valid;
      wb_sel      <= i_wb_sel;
      wb_dmem_wen <= o_dmem_wen;
    end
  end

  always_ff @(posedge i_clk) begin
    wb_inst       <= i_inst;
    wb_pc         <= i_pc;
    wb_next_pc    <= i_next_pc;
    wb_result     <= i_result;
    wb_store_data <= i_store_data;
    wb_rd         <= i_rd;
  end

  // load data arrives from dmem in this cycle and is used as it comes
  assign wb_data  = (wb_sel == WB_MEM) ? i_dmem_rdata : wb_result;
  assign wb_write = wb_valid && (wb_sel != WB_NONE);

  assign o_rf_wen   = wb_write;
  assign o_rf_waddr = wb_rd;
  assign o_rf_wdata = wb_data;

  assign o_retire_valid      = wb_valid;
  assign o_retire_inst       = wb_inst;
  assign o_retire_halt       = (wb_inst == EBREAK_WORD);
  assign o_retire_pc         = wb_pc;
  assign o_retire_next_pc    = wb_next_pc;
  assign o_retire_rd_waddr   = wb_write ? wb_rd : '0; // zero when nothing is written
  assign o_retire_rd_wdata   = wb_data;
  assign o_retire_dmem_wen   = wb_dmem_wen;
  assign o_retire_dmem_addr  = wb_result;
  assign o_retire_dmem_wdata = wb_store_data;

endmodule

//--- src/hart.sv
`timescale 1ns/1ps

module hart (
  input  logic               i_clk,
  input  logic               i_rst,
  output pipe_pkg::pc_t      o_imem_raddr,
  input  isa_pkg::word_t     i_imem_rdata,
  output isa_pkg::word_t     o_dmem_addr,
  output logic               o_dmem_ren,
  output logic               o_dmem_wen,
  output isa_pkg::word_t     o_dmem_wdata,
  input  isa_pkg::word_t     i_dmem_rdata,
  output logic               o_retire_valid,
  output isa_pkg::word_t     o_retire_inst,
  output logic               o_retire_halt,
  output pipe_pkg::pc_t      o_retire_pc,
  output pipe_pkg::pc_t      o_retire_next_pc,
  output isa_pkg::reg_addr_t o_retire_rd_waddr,
  output isa_pkg::word_t     o_retire_rd_wdata,
  output logic               o_retire_dmem_wen,
  output isa_pkg::word_t     o_retire_dmem_addr,
  output isa_pkg::word_t     o_retire_dmem_wdata
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic      id_valid;     // fetch to decode
  word_t     id_inst;
  pc_t       id_pc;
  logic      stall;
  logic      redirect;     // taken branch in execute
  pc_t       redirect_pc;
  logic      ex_valid;     // decode to execute
  word_t     ex_inst;
  pc_t       ex_pc;
  word_t     ex_op_a;
  word_t     ex_op_b;
  word_t     ex_store_data;
  word_t     ex_imm;
  alu_op_e   ex_alu_op;
  wb_sel_e   ex_wb_sel;
  reg_addr_t ex_rd;
  logic      ex_mem_ren;
  logic      ex_mem_wen;
  logic      ex_branch;
  logic      ex_branch_ne;
  reg_addr_t haz_ex_rd;    // producers that decode has to wait for
  logic      haz_ex_wen;
  reg_addr_t haz_mem_rd;
  logic      haz_mem_wen;
  logic      mem_valid;    // execute to memory
  word_t     mem_inst;
  pc_t       mem_pc;
  pc_t       mem_next_pc;
  word_t     mem_result;
  word_t     mem_store_data;
  reg_addr_t mem_rd;
  wb_sel_e   mem_wb_sel;
  logic      mem_ren;
  logic      mem_wen;
  logic      rf_wen;       // writeback into the register file
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  rf_read_if rf_rd ();

  fetch_unit fetch_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_imem_rdata(i_imem_rdata),
    .i_stall(stall), .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .o_imem_raddr(o_imem_raddr), .o_id_valid(id_valid), .o_id_inst(id_inst),
    .o_id_pc(id_pc)
  );

  decode_unit decode_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(id_valid), .i_inst(id_inst), .i_pc(id_pc),
    .rf(rf_rd.decoder),
    .i_ex_rd(haz_ex_rd), .i_ex_wen(haz_ex_wen), .i_mem_rd(haz_mem_rd),
    .i_mem_wen(haz_mem_wen), .i_redirect(redirect), .o_stall(stall),
    .o_ex_valid(ex_valid), .o_ex_inst(ex_inst), .o_ex_pc(ex_pc),
    .o_ex_op_a(ex_op_a), .o_ex_op_b(ex_op_b), .o_ex_store_data(ex_store_data),
    .o_ex_imm(ex_imm), .o_ex_alu_op(ex_alu_op), .o_ex_wb_sel(ex_wb_sel), .o_ex_rd(ex_rd),
    .o_ex_mem_ren(ex_mem_ren), .o_ex_mem_wen(ex_mem_wen), .o_ex_branch(ex_branch),
    .o_ex_branch_ne(ex_branch_ne)
  );

  reg_file regs_i (
    .i_clk(i_clk), .i_rst(i_rst), .rf(rf_rd.regs),
    .i_wen(rf_wen), .i_waddr(rf_waddr), .i_wdata(rf_wdata)
  );

  execute_unit execute_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(ex_valid), .i_inst(ex_inst), .i_pc(ex_pc),
    .i_op_a(ex_op_a), .i_op_b(ex_op_b), .i_store_data(ex_store_data), .i_imm(ex_imm),
    .i_alu_op(ex_alu_op), .i_wb_sel(ex_wb_sel), .i_rd(ex_rd), .i_mem_ren(ex_mem_ren),
    .i_mem_wen(ex_mem_wen), .i_branch(ex_branch), .i_branch_ne(ex_branch_ne),
    .o_redirect(redirect), .o_redirect_pc(redirect_pc),
    .o_ex_rd(haz_ex_rd), .o_ex_wen(haz_ex_wen),
    .o_mem_valid(mem_valid), .o_mem_inst(mem_inst), .o_mem_pc(mem_pc),
    .o_mem_next_pc(mem_next_pc), .o_mem_result(mem_result),
    .o_mem_store_data(mem_store_data), .o_mem_rd(mem_rd), .o_mem_wb_sel(mem_wb_sel),
    .o_mem_ren(mem_ren), .o_mem_wen(mem_wen)
  );

  mem_wb_unit mem_wb_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(mem_valid), .i_inst(mem_inst), .i_pc(mem_pc),
    .i_next_pc(mem_next_pc), .i_result(mem_result), .i_store_data(mem_store_data),
    .i_rd(mem_rd), .i_wb_sel(mem_wb_sel), .i_ren(mem_ren), .i_wen(mem_wen),
    .o_mem_rd(haz_mem_rd), .o_mem_wen(haz_mem_wen),
    .o_dmem_addr(o_dmem_addr), .o_dmem_ren(o_dmem_ren), .o_dmem_wen(o_dmem_wen),
    .o_dmem_wdata(o_dmem_wdata), .i_dmem_rdata(i_dmem_rdata),
    .o_rf_wen(rf_wen), .o_rf_waddr(rf_waddr), .o_rf_wdata(rf_wdata),
    .o_retire_valid(o_retire_valid), .o_retire_inst(o_retire_inst),
    .o_retire_halt(o_retire_halt), .o_retire_pc(o_retire_pc),
    .o_retire_next_pc(o_retire_next_pc), .o_retire_rd_waddr(o_retire_rd_waddr),
    .o_retire_rd_wdata(o_retire_rd_wdata), .o_retire_dmem_wen(o_retire_dmem_wen),
    .o_retire_dmem_addr(o_retire_dmem_addr), .o_retire_dmem_wdata(o_retire_dmem_wdata)
  );

endmodule

//--- test/hart_properties.sv
`timescale 1ns/1ps

module hart_properties (
  input logic        i_clk,
  input logic        i_rst,
  input logic [31:0] o_imem_raddr,
  input logic        o_dmem_ren,
  input logic        o_dmem_wen,
  input logic        o_retire_valid
);

  // a single-port data memory can do one access per cycle
  one_dmem_access: assert property (@(posedge i_clk) !(o_dmem_ren && o_dmem_wen))
    else $error("dmem read and write enabled in the same cycle");

  // the pipeline is empty during reset and in the cycle that follows it
  quiet_after_reset: assert property (@(posedge i_clk)
    (i_rst || $past(i_rst)) |-> !(o_retire_valid || o_dmem_ren || o_dmem_wen))
    else $error("retire or dmem enable seen during or right after reset");

  word_aligned_fetch: assert property (@(posedge i_clk) disable iff (i_rst)
    o_imem_raddr[1:0] == 2'b00)
    else $error("instruction fetch address is not word aligned");

endmodule

bind hart hart_properties props_i (
  .i_clk(i_clk),
  .i_rst(i_rst),
  .o_imem_raddr(o_imem_raddr),
  .o_dmem_ren(o_dmem_ren),
  .o_dmem_wen(o_dmem_wen),
  .o_retire_valid(o_retire_valid)
);

//--- test/hart_tb.sv
`timescale 1ns/1ps

module hart_tb;
  import isa_pkg::*;

  logic        i_clk;
  logic        i_rst;
  logic [31:0] o_imem_raddr;
  word_t       i_imem_rdata;
  word_t       o_dmem_addr;
  logic        o_dmem_ren;
  logic        o_dmem_wen;
  word_t       o_dmem_wdata;
  word_t       i_dmem_rdata;
  logic        o_retire_valid;
  word_t       o_retire_inst;
  logic        o_retire_halt;
  logic [31:0] o_retire_pc;
  logic [31:0] o_retire_next_pc;
  reg_addr_t   o_retire_rd_waddr;
  word_t       o_retire_rd_wdata;
  logic        o_retire_dmem_wen;
  word_t       o_retire_dmem_addr;
  word_t       o_retire_dmem_wdata;

  word_t       imem [256]; // indexed by address bits 9:2
  word_t       dmem [256];
  logic [31:0] imem_addr_q; // address captured at the rising edge
  logic [31:0] dmem_addr_q;

  string       prog_name [$]; // stimulus table, one entry per program word
  word_t       prog_word [$];
  logic [31:0] rnd_state;

  string       exp_name [$]; // expected retire sequence from the model
  word_t       exp_inst [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_next_pc [$];
  reg_addr_t   exp_rd [$];
  word_t       exp_wdata [$];
  logic        exp_store [$];
  word_t       exp_addr [$];
  word_t       exp_sdata [$];
  logic        exp_halt [$];

  int          errors;
  int          cycles;
  int          limit;
  int          idx;
  logic        done;
  logic [31:0] last_next_pc;

  hart hart_i (.*);

  always #4 i_clk = ~i_clk;

  // synchronous memories, word returns in the cycle after the address
  always @(posedge i_clk) begin
    imem_addr_q <= o_imem_raddr;
    if (o_dmem_ren) dmem_addr_q <= o_dmem_addr; // the read register only loads on a read
    if (o_dmem_wen) dmem[o_dmem_addr[9:2]] <= o_dmem_wdata;
  end

  always @(negedge i_clk) begin
    i_imem_rdata <= imem[imem_addr_q[9:2]];
    i_dmem_rdata <= dmem[dmem_addr_q[9:2]];
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd_state = xorshift(rnd_state);
    return rnd_state;
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  funct3_t f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                  reg_addr_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  task automatic add_inst(string name, word_t w);
    prog_name.push_back(name);
    prog_word.push_back(w);
  endtask

  task automatic build_program();
    add_inst("lui_rand", {20'(next_rand()), 5'd1, OP_LUI});
    add_inst("addi_dep", enc_i(12'(next_rand()), 5'd1, 3'b000, 5'd1, OP_IMM));
    add_inst("addi_x2", enc_i(12'(next_rand()), 5'd0, 3'b000, 5'd2, OP_IMM));
    add_inst("add", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    add_inst("sub", enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
    add_inst("and", enc_r(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));
    add_inst("or", enc_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd6));
    add_inst("xor", enc_r(7'h00, 5'd1, 5'd6, 3'b100, 5'd7));
    add_inst("slt", enc_r(7'h00, 5'd1, 5'd7, 3'b010, 5'd8));
    add_inst("addi_shamt", enc_i(12'd5, 5'd0, 3'b000, 5'd9, OP_IMM));
    add_inst("sll", enc_r(7'h00, 5'd9, 5'd3, 3'b001, 5'd10));
    add_inst("srl", enc_r(7'h00, 5'd9, 5'd10, 3'b101, 5'd11));
    add_inst("andi", enc_i(12'(next_rand()), 5'd11, 3'b111, 5'd12, OP_IMM));
    add_inst("ori", enc_i(12'(next_rand()), 5'd12, 3'b110, 5'd13, OP_IMM));
    add_inst("xori", enc_i(12'(next_rand()), 5'd13, 3'b100, 5'd14, OP_IMM));
    add_inst("slti", enc_i(12'(next_rand()), 5'd14, 3'b010, 5'd15, OP_IMM));
    add_inst("addi_base", enc_i(12'h100, 5'd0, 3'b000, 5'd16, OP_IMM));
    add_inst("sw", enc_s(12'd8, 5'd7, 5'd16));
    add_inst("lw", enc_i(12'd8, 5'd16, 3'b010, 5'd17, OP_LOAD));
    add_inst("addi_x0", enc_i(12'd123, 5'd0, 3'b000, 5'd0, OP_IMM));
    add_inst("add_read_x0", enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd18));
    add_inst("beq_taken", enc_b(13'd12, 5'd7, 5'd17, F3_BEQ));
    add_inst("skipped_a", enc_i(12'd1, 5'd0, 3'b000, 5'd19, OP_IMM));
    add_inst("skipped_b", enc_i(12'd2, 5'd0, 3'b000, 5'd19, OP_IMM));
    add_inst("bne_not_taken", enc_b(13'd8, 5'd7, 5'd17, F3_BNE));
    add_inst("bne_taken", enc_b(13'd8, 5'd0, 5'd9, F3_BNE));
    add_inst("skipped_c", enc_i(12'd3, 5'd0, 3'b000, 5'd20, OP_IMM));
    add_inst("beq_not_taken", enc_b(13'd8, 5'd0, 5'd9, F3_BEQ));
    add_inst("ebreak", EBREAK_WORD);
  endtask

  // walks the program the way the ISA defines it and records each retire
  task automatic run_model();
    word_t       regs_m [32];
    word_t       mem_m [256];
    logic [31:0] pc;
    logic [31:0] npc;
    word_t       inst;
    word_t       a;
    word_t       b;
    word_t       res;
    word_t       imm_i;
    word_t       addr;
    logic        wr;
    logic        st;
    int          steps;
    for (int i = 0; i < 32; i++) regs_m[i] = '0;
    for (int i = 0; i < 256; i++) mem_m[i] = dmem[i];
    pc = 32'h0;
    for (steps = 0; steps < 64; steps++) begin
      inst  = imem[pc[9:2]];
      a     = regs_m[inst[19:15]];
      b     = regs_m[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      npc   = pc + 32'd4;
      wr    = 1'b0;
      st    = 1'b0;
      res   = '0;
      addr  = '0;
      case (inst[6:0])
        OP_REG, OP_IMM: begin
          if (inst[6:0] == OP_IMM) b = imm_i; // immediate replaces rs2
          wr = 1'b1;
          case (inst[14:12])
            3'b000: res = (inst[6:0] == OP_REG && inst[30]) ? a - b : a + b;
            3'b010: res = {31'b0, $signed(a) < $signed(b)};
            3'b100: res = a ^ b;
            3'b110: res = a | b;
            3'b111: res = a & b;
            3'b001: res = a << b[4:0];
            3'b101: res = a >> b[4:0];
            default: wr = 1'b0;
          endcase
          if (inst[6:0] == OP_IMM && (inst[14:12] == 3'b001 || inst[14:12] == 3'b101))
            wr = 1'b0; // immediate shifts are not part of the subset
        end
        OP_LUI: begin
          res = {inst[31:12], 12'b0};
          wr  = 1'b1;
        end
        OP_LOAD: begin
          addr = a + imm_i;
          res  = mem_m[addr[9:2]];
          wr   = 1'b1;
        end
        OP_STORE: begin
          addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          mem_m[addr[9:2]] = b;
          st = 1'b1;
        end
        OP_BRANCH: begin
          if ((inst[14:12] == F3_BEQ && a == b) || (inst[14:12] == F3_BNE && a != b))
            npc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        default: ;
      endcase
      if (wr && inst[11:7] != 5'd0) regs_m[inst[11:7]] = res;
      exp_name.push_back(prog_name[pc[9:2]]);
      exp_inst.push_back(inst);
      exp_pc.push_back(pc);
      exp_next_pc.push_back(npc);
      exp_rd.push_back(wr ? inst[11:7] : 5'd0);
      exp_wdata.push_back(res);
      exp_store.push_back(st);
      exp_addr.push_back(addr);
      exp_sdata.push_back(b);
      exp_halt.push_back(inst == EBREAK_WORD);
      if (inst == EBREAK_WORD) break;
      pc = npc;
    end
  endtask

  task automatic check_field(string name, string field, logic [31:0] exp, logic [31:0] act);
    assert (exp === act)
    else begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  task automatic check_retire();
    string nm;
    if (idx >= exp_pc.size()) begin
      errors++;
      $display("an instruction retired after the expected sequence had ended");
      return;
    end
    nm = exp_name[idx];
    check_field(nm, "inst", exp_inst[idx], o_retire_inst);
    check_field(nm, "pc", exp_pc[idx], o_retire_pc);
    if (idx > 0) check_field(nm, "pc follows next_pc", last_next_pc, o_retire_pc);
    check_field(nm, "next_pc", exp_next_pc[idx], o_retire_next_pc);
    check_field(nm, "rd", {27'b0, exp_rd[idx]}, {27'b0, o_retire_rd_waddr});
    if (exp_rd[idx] != 5'd0) check_field(nm, "rd_wdata", exp_wdata[idx], o_retire_rd_wdata);
    check_field(nm, "dmem_wen", {31'b0, exp_store[idx]}, {31'b0, o_retire_dmem_wen});
    if (exp_store[idx]) begin
      check_field(nm, "dmem_addr", exp_addr[idx], o_retire_dmem_addr);
      check_field(nm, "dmem_wdata", exp_sdata[idx], o_retire_dmem_wdata);
    end
    check_field(nm, "halt", {31'b0, exp_halt[idx]}, {31'b0, o_retire_halt});
    last_next_pc = o_retire_next_pc;
    if (exp_halt[idx]) done = 1'b1;
    idx++;
  endtask

  initial begin
    i_clk        = 1'b0;
    i_rst        = 1'b1;
    i_imem_rdata = '0;
    i_dmem_rdata = '0;
    imem_addr_q  = '0;
    dmem_addr_q  = '0;
    errors       = 0;
    cycles       = 0;
    idx          = 0;
    done         = 1'b0;
    last_next_pc = '0;
    rnd_state    = 32'h1dfc;
    // unused imem holds lui x0 words that vary with the address
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[19:0] ^ 20'h5a5a5, 5'd0, OP_LUI};
      dmem[i] = (i * 32'h9e3779b9) ^ 32'h5bd1e995;
    end
    build_program();
    for (int i = 0; i < prog_word.size(); i++) imem[i] = prog_word[i];
    run_model();
    limit = 4 * exp_pc.size() + 20;

    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    while (!done && cycles < limit) begin
      @(posedge i_clk);
      cycles++;
      if (o_retire_valid) check_retire(); // outputs settled since the falling edge
    end

    if (!done) begin
      $display("timeout after %0d cycles with %0d of %0d instructions retired",
               cycles, idx, exp_pc.size());
      errors++;
    end
    $display("errors: %0d, retired %0d of %0d", errors, idx, exp_pc.size());
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/rf_read_if.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/mem_wb_unit.sv
src/hart.sv
test/hart_properties.sv
test/hart_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module hart_tb -o hart_sim
./obj_dir/hart_sim > sim.log
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
  exit 0
else
  exit 1
fi
